/* verilog/msx_pkg.sv */
package msx_pkg;

   typedef enum logic {
      MSX1 = 1'b0,
      MSX2 = 1'b1
   } machine_t;

   // ram_size 0..3 selects 64, 128, 256 or 512 KB of mapped RAM
   typedef struct packed {
      machine_t   typ;
      logic [1:0] ram_size;
   } config_t;

   typedef struct packed {
      logic       io_wr;
      logic       io_rd;
      // level, high for the length of a memory cycle
      logic       mem;
      logic       rd_act;
      logic [7:0] port;
      logic [1:0] page;
      logic [7:0] wdata;
      logic [5:0] addr_lo;
   } bus_req_t;

   // second byte of a 99h pair
   typedef union packed {
      struct packed {
         logic       flag;
         logic       spare;
         logic [5:0] reg_num;
      } reg_wr;
      struct packed {
         logic       flag;
         logic       write_mode;
         logic [5:0] addr_bits;
      } addr_hi;
   } vdp_ctrl_t;

   localparam logic [7:0] PORT_VDP_DATA = 8'h98;
   localparam logic [7:0] PORT_VDP_CTRL = 8'h99;
   localparam logic [7:0] PORT_SLOT     = 8'hA8;
   // FCh..FFh, one register per page
   localparam logic [7:0] PORT_MAPPER   = 8'hFC;

   // one physical bank
   localparam int VRAM_AW      = 16;
   localparam int MSX1_VRAM_AW = 14;
   localparam int MSX2_VRAM_AW = 17;

endpackage

/* verilog/spram.sv */
`timescale 1ns/100ps

module spram #(
   parameter int addr_width = 16
) (
   input  logic                  clock,
   input  logic [addr_width-1:0] address,
   input  logic                  wren,
   input  logic [7:0]            data,
   output logic [7:0]            q
);

   logic [7:0] mem [0:(2**addr_width)-1];

   // read returns the old word on a write cycle
   always_ff @(posedge clock) begin
      if (wren) mem[address] <= data;
      q <= mem[address];
   end

endmodule

/* verilog/msx_bus_decode.sv */
`timescale 1ns/100ps

module msx_bus_decode (
   input  logic              clk21m,
   input  logic              ce_10m7_p,
   input  logic              reset,
   input  logic [15:0]       addr,
   input  logic [7:0]        d_from_cpu,
   input  logic              wr_n,
   input  logic              rd_n,
   input  logic              iorq_n,
   input  logic              mreq_n,
   output msx_pkg::bus_req_t req
);

   logic       wr_n_q;
   logic       rd_n_q;
   logic       wr_fall;
   logic       rd_fall;
   logic       io_wr;
   logic       io_rd;
   logic       mem;
   logic       rd_act;
   logic [7:0] port_q;
   logic [1:0] page_q;
   logic [7:0] wdata_q;
   logic [5:0] addr_lo_q;

   // strobe edges only count on enabled cycles
   assign wr_fall = ce_10m7_p && !iorq_n && !wr_n && wr_n_q;
   assign rd_fall = ce_10m7_p && !iorq_n && !rd_n && rd_n_q;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         wr_n_q <= 1'b1;
         rd_n_q <= 1'b1;
         io_wr  <= 1'b0;
         io_rd  <= 1'b0;
         mem    <= 1'b0;
         rd_act <= 1'b0;
      end else begin
         if (ce_10m7_p) begin
            wr_n_q <= wr_n;
            rd_n_q <= rd_n;
         end
         io_wr <= wr_fall;
         io_rd <= rd_fall;
         mem   <= !mreq_n;
         // drops on the first clock after the read strobe goes away
         if (rd_n || iorq_n) rd_act <= 1'b0;
         else if (rd_fall) rd_act <= 1'b1;
      end
   end

   always_ff @(posedge clk21m) begin
      if (wr_fall || rd_fall) begin
         port_q    <= addr[7:0];
         addr_lo_q <= addr[5:0];
      end
      if (wr_fall) wdata_q <= d_from_cpu;
      if (!mreq_n) page_q <= addr[15:14];
   end

   assign req = '{io_wr: io_wr, io_rd: io_rd, mem: mem, rd_act: rd_act,
                  port: port_q, page: page_q, wdata: wdata_q,
                  addr_lo: addr_lo_q};

endmodule

/* verilog/msx1_core.sv */
`timescale 1ns/100ps

module msx1_core (
   input  logic                        clk21m,
   input  logic                        reset,
   input  msx_pkg::bus_req_t           req,
   input  logic [7:0]                  vram_q,
   output logic [7:0]                  d_to_cpu,
   output logic                        dataBusRQ,
   output logic [7:0]                  ram_bank,
   output logic [3:0]                  SLTSL_n,
   output logic [msx_pkg::VRAM_AW-1:0] vram_addr,
   output logic [7:0]                  vram_do,
   output logic                        vram_we
);

   logic [7:0]                      slot;
   logic [msx_pkg::MSX1_VRAM_AW-1:0] vaddr;
   logic [7:0]                      ctrl_lo;
   logic                            ctrl_second;
   logic [7:0]                      rd_buf;
   logic [1:0]                      fetch;
   logic                            rd_pend;
   msx_pkg::vdp_ctrl_t              ctrl;
   logic                            wr_data;
   logic                            wr_ctrl;
   logic                            wr_slot;
   logic                            rd_data;

   assign ctrl    = req.wdata;
   assign wr_data = req.io_wr && req.port == msx_pkg::PORT_VDP_DATA;
   assign wr_ctrl = req.io_wr && req.port == msx_pkg::PORT_VDP_CTRL;
   assign wr_slot = req.io_wr && req.port == msx_pkg::PORT_SLOT;
   assign rd_data = req.io_rd && req.port == msx_pkg::PORT_VDP_DATA;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         slot        <= '0;
         vaddr       <= '0;
         ctrl_second <= 1'b0;
         fetch       <= '0;
         rd_pend     <= 1'b0;
      end else begin
         fetch <= {fetch[0], 1'b0};
         if (wr_slot) slot <= req.wdata;
         if (wr_ctrl) begin
            ctrl_second <= !ctrl_second;
            if (ctrl_second && !ctrl.addr_hi.flag) begin
               vaddr    <= {ctrl.addr_hi.addr_bits, ctrl_lo};
               fetch[0] <= 1'b1;
            end
         end
         // read advances the address once the CPU lets go of the bus
         if (rd_data) begin
            rd_pend <= 1'b1;
         end else if (rd_pend && !req.rd_act) begin
            rd_pend <= 1'b0;
         end
         if (wr_data || (rd_pend && !req.rd_act)) begin
            vaddr    <= vaddr + 1'b1;
            fetch[0] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (wr_ctrl && !ctrl_second) ctrl_lo <= req.wdata;
      // q belongs to the address set two cycles back
      if (fetch[1]) rd_buf <= vram_q;
   end

   assign vram_addr = {{(msx_pkg::VRAM_AW - msx_pkg::MSX1_VRAM_AW){1'b0}}, vaddr};
   assign vram_do   = req.wdata;
   assign vram_we   = wr_data;

   // no mapper, bank is the page
   assign ram_bank = {6'd0, req.page};

   always_comb begin
      SLTSL_n = 4'b1111;
      if (req.mem) SLTSL_n[slot[{req.page, 1'b0} +: 2]] = 1'b0;
   end

   assign dataBusRQ = req.rd_act && (req.port == msx_pkg::PORT_VDP_DATA ||
                                     req.port == msx_pkg::PORT_SLOT);
   assign d_to_cpu  = req.port == msx_pkg::PORT_SLOT ? slot : rd_buf;

endmodule

/* verilog/msx2_core.sv */
`timescale 1ns/100ps

module msx2_core (
   input  logic                        clk21m,
   input  logic                        reset,
   input  msx_pkg::config_t            conf,
   input  msx_pkg::bus_req_t           req,
   input  logic [7:0]                  vram_q,
   input  logic [7:0]                  vram_q_hi,
   output logic [7:0]                  d_to_cpu,
   output logic                        dataBusRQ,
   output logic [7:0]                  ram_bank,
   output logic [3:0]                  SLTSL_n,
   output logic [msx_pkg::VRAM_AW-1:0] vram_addr,
   output logic [7:0]                  vram_do,
   output logic                        vram_we_lo,
   output logic                        vram_we_hi
);

   localparam int HI = msx_pkg::MSX2_VRAM_AW - 1;
   localparam int LO = msx_pkg::MSX1_VRAM_AW;

   logic [7:0]               slot;
   logic [7:0]               mapper [0:3];
   logic [7:0]               map_mask;
   logic [HI:0]              vaddr;
   logic [7:0]               ctrl_lo;
   logic                     ctrl_second;
   logic [7:0]               rd_buf;
   logic [1:0]               fetch;
   logic                     rd_pend;
   msx_pkg::vdp_ctrl_t       ctrl;
   logic                     wr_data;
   logic                     wr_ctrl;
   logic                     wr_slot;
   logic                     wr_map;
   logic                     rd_data;
   logic                     map_sel;

   assign ctrl    = req.wdata;
   assign map_sel = req.port[7:2] == msx_pkg::PORT_MAPPER[7:2];
   assign wr_data = req.io_wr && req.port == msx_pkg::PORT_VDP_DATA;
   assign wr_ctrl = req.io_wr && req.port == msx_pkg::PORT_VDP_CTRL;
   assign wr_slot = req.io_wr && req.port == msx_pkg::PORT_SLOT;
   assign wr_map  = req.io_wr && map_sel;
   assign rd_data = req.io_rd && req.port == msx_pkg::PORT_VDP_DATA;

   // 2 bits at 64 KB up to 5 bits at 512 KB
   assign map_mask = 8'hFF >> (3'd6 - {1'b0, conf.ram_size});

   always_ff @(posedge clk21m) begin
      if (reset) begin
         slot        <= '0;
         vaddr       <= '0;
         ctrl_second <= 1'b0;
         fetch       <= '0;
         rd_pend     <= 1'b0;
         for (int i = 0; i < 4; i++) mapper[i] <= 8'(3 - i);
      end else begin
         fetch <= {fetch[0], 1'b0};
         if (wr_slot) slot <= req.wdata;
         if (wr_map) mapper[req.port[1:0]] <= req.wdata & map_mask;
         if (wr_ctrl) begin
            ctrl_second <= !ctrl_second;
            if (ctrl_second && !ctrl.addr_hi.flag) begin
               vaddr[LO-1:0] <= {ctrl.addr_hi.addr_bits, ctrl_lo};
               fetch[0]      <= 1'b1;
            end
            // R#14 holds the top address bits
            if (ctrl_second && ctrl.reg_wr.flag && ctrl.reg_wr.reg_num == 6'd14)
               vaddr[HI:LO] <= ctrl_lo[2:0];
         end
         if (rd_data) begin
            rd_pend <= 1'b1;
         end else if (rd_pend && !req.rd_act) begin
            rd_pend <= 1'b0;
         end
         // carry runs into R#14, wraps at 128 KB
         if (wr_data || (rd_pend && !req.rd_act)) begin
            vaddr    <= vaddr + 1'b1;
            fetch[0] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (wr_ctrl && !ctrl_second) ctrl_lo <= req.wdata;
      if (fetch[1]) rd_buf <= vaddr[HI] ? vram_q_hi : vram_q;
   end

   // bit 16 picks the bank
   assign vram_addr  = vaddr[msx_pkg::VRAM_AW-1:0];
   assign vram_do    = req.wdata;
   assign vram_we_lo = wr_data && !vaddr[HI];
   assign vram_we_hi = wr_data && vaddr[HI];

   assign ram_bank = mapper[req.page];

   always_comb begin
      SLTSL_n = 4'b1111;
      if (req.mem) SLTSL_n[slot[{req.page, 1'b0} +: 2]] = 1'b0;
   end

   assign dataBusRQ = req.rd_act && (req.port == msx_pkg::PORT_VDP_DATA ||
                                     req.port == msx_pkg::PORT_SLOT || map_sel);

   always_comb begin
      if (req.port == msx_pkg::PORT_SLOT) d_to_cpu = slot;
      // unused high bits read back as ones
      else if (map_sel) d_to_cpu = mapper[req.addr_lo[1:0]] | ~map_mask;
      else d_to_cpu = rd_buf;
   end

endmodule

/* verilog/msx_select.sv */
`timescale 1ns/100ps

module msx_select (
   input  logic              clk21m,
   input  logic              reset,
   input  msx_pkg::config_t  conf,
   input  msx_pkg::bus_req_t req,
   output logic [7:0]        d_to_cpu,
   output logic              dataBusRQ,
   output logic [7:0]        ram_bank,
   output logic [3:0]        SLTSL_n
);

   logic                        is_msx1;
   msx_pkg::bus_req_t           req_msx1;
   msx_pkg::bus_req_t           req_msx2;
   logic [7:0]                  d_to_cpu_msx1;
   logic [7:0]                  d_to_cpu_msx2;
   logic                        dataBusRQ_msx1;
   logic                        dataBusRQ_msx2;
   logic [7:0]                  ram_bank_msx1;
   logic [7:0]                  ram_bank_msx2;
   logic [3:0]                  SLTSL_n_msx1;
   logic [3:0]                  SLTSL_n_msx2;
   logic [msx_pkg::VRAM_AW-1:0] vram_addr_msx1;
   logic [msx_pkg::VRAM_AW-1:0] vram_addr_msx2;
   logic [msx_pkg::VRAM_AW-1:0] vram_addr;
   logic [7:0]                  vram_do_msx1;
   logic [7:0]                  vram_do_msx2;
   logic [7:0]                  vram_do;
   logic                        vram_we_msx1;
   logic                        vram_we_lo_msx2;
   logic                        vram_we_hi_msx2;
   logic                        vram_we_lo;
   logic                        vram_we_hi;
   logic [7:0]                  vram_di_lo;
   logic [7:0]                  vram_di_hi;

   assign is_msx1 = conf.typ == msx_pkg::MSX1;

   // idle core sees no I/O strobes and keeps its state
   always_comb begin
      req_msx1 = req;
      req_msx2 = req;
      if (!is_msx1) begin
         req_msx1.io_wr = 1'b0;
         req_msx1.io_rd = 1'b0;
      end else begin
         req_msx2.io_wr = 1'b0;
         req_msx2.io_rd = 1'b0;
      end
   end

   msx1_core msx1 (
      .clk21m(clk21m), .reset(reset), .req(req_msx1), .vram_q(vram_di_lo),
      .d_to_cpu(d_to_cpu_msx1), .dataBusRQ(dataBusRQ_msx1), .ram_bank(ram_bank_msx1),
      .SLTSL_n(SLTSL_n_msx1), .vram_addr(vram_addr_msx1), .vram_do(vram_do_msx1),
      .vram_we(vram_we_msx1)
   );

   msx2_core msx2 (
      .clk21m(clk21m), .reset(reset), .conf(conf), .req(req_msx2),
      .vram_q(vram_di_lo), .vram_q_hi(vram_di_hi),
      .d_to_cpu(d_to_cpu_msx2), .dataBusRQ(dataBusRQ_msx2), .ram_bank(ram_bank_msx2),
      .SLTSL_n(SLTSL_n_msx2), .vram_addr(vram_addr_msx2), .vram_do(vram_do_msx2),
      .vram_we_lo(vram_we_lo_msx2), .vram_we_hi(vram_we_hi_msx2)
   );

   assign vram_addr  = is_msx1 ? vram_addr_msx1 : vram_addr_msx2;
   assign vram_do    = is_msx1 ? vram_do_msx1   : vram_do_msx2;
   assign vram_we_lo = is_msx1 ? vram_we_msx1   : vram_we_lo_msx2;
   assign vram_we_hi = is_msx1 ? 1'b0           : vram_we_hi_msx2;

   spram #(.addr_width(msx_pkg::VRAM_AW)) vram_lo (
      .clock(clk21m), .address(vram_addr), .wren(vram_we_lo), .data(vram_do),
      .q(vram_di_lo)
   );

   spram #(.addr_width(msx_pkg::VRAM_AW)) vram_hi (
      .clock(clk21m), .address(vram_addr), .wren(vram_we_hi), .data(vram_do),
      .q(vram_di_hi)
   );

   assign d_to_cpu  = is_msx1 ? d_to_cpu_msx1  : d_to_cpu_msx2;
   assign dataBusRQ = is_msx1 ? dataBusRQ_msx1 : dataBusRQ_msx2;
   assign ram_bank  = is_msx1 ? ram_bank_msx1  : ram_bank_msx2;
   assign SLTSL_n   = is_msx1 ? SLTSL_n_msx1   : SLTSL_n_msx2;

endmodule

/* verilog/msx_top.sv */
`timescale 1ns/100ps

module msx_top (
   input  logic             clk21m,
   input  logic             ce_10m7_p,
   input  logic             reset,
   input  msx_pkg::config_t conf,
   input  logic [15:0]      addr,
   input  logic [7:0]       d_from_cpu,
   input  logic             wr_n,
   input  logic             rd_n,
   input  logic             iorq_n,
   input  logic             mreq_n,
   output logic [7:0]       d_to_cpu,
   output logic             dataBusRQ,
   output logic [7:0]       ram_bank,
   output logic [3:0]       SLTSL_n
);

   msx_pkg::bus_req_t req;

   msx_bus_decode bus_decode (
      .clk21m(clk21m), .ce_10m7_p(ce_10m7_p), .reset(reset), .addr(addr),
      .d_from_cpu(d_from_cpu), .wr_n(wr_n), .rd_n(rd_n), .iorq_n(iorq_n),
      .mreq_n(mreq_n), .req(req)
   );

   msx_select select (
      .clk21m(clk21m), .reset(reset), .conf(conf), .req(req), .d_to_cpu(d_to_cpu),
      .dataBusRQ(dataBusRQ), .ram_bank(ram_bank), .SLTSL_n(SLTSL_n)
   );

endmodule

/* verif/msx_chk.sv */
`timescale 1ns/100ps

module msx_chk (
   input logic       clk21m,
   input logic       reset,
   input logic       rd_n,
   input logic       iorq_n,
   input logic       mreq_n,
   input logic       dataBusRQ,
   input logic [3:0] SLTSL_n
);

   int fail_count = 0;

   // bus claimed only during an I/O read or on the clock right after it
   rq_in_read: assert property (@(posedge clk21m) disable iff (reset)
      dataBusRQ |-> (!rd_n && !iorq_n) || $past(!rd_n && !iorq_n))
      else begin
         fail_count++;
         $error("dataBusRQ is high outside an I/O read");
      end

   // one select low in a memory cycle, none outside it
   one_slot: assert property (@(posedge clk21m) disable iff (reset)
      $past(mreq_n) ? SLTSL_n == 4'hF : $onehot(~SLTSL_n))
      else begin
         fail_count++;
         $error("slot selects do not match the memory cycle");
      end

   rq_after_reset: assert property (@(posedge clk21m) reset |=> !dataBusRQ)
      else begin
         fail_count++;
         $error("dataBusRQ is high right after reset");
      end

endmodule

bind msx_top msx_chk chk (
   .clk21m(clk21m), .reset(reset), .rd_n(rd_n), .iorq_n(iorq_n), .mreq_n(mreq_n),
   .dataBusRQ(dataBusRQ), .SLTSL_n(SLTSL_n)
);

/* verif/tb_msx.sv */
`timescale 1ns/100ps

module tb_msx;

   localparam int STROBE_CYC = 8;
   localparam int IDLE_CYC   = 6;
   localparam int OP_NS      = (STROBE_CYC + IDLE_CYC) * 10;
   // generous bound on bus operations over all tests
   localparam int MAX_OPS    = 800;
   localparam int TIMEOUT_NS = MAX_OPS * OP_NS + 2000;

   typedef struct packed {
      logic       is_mem;
      logic       rq;
      logic [7:0] d;
      logic [7:0] bank;
      logic [3:0] sltsl_n;
   } result_t;

   logic             clk21m = 1'b0;
   logic             ce_10m7_p;
   logic             reset;
   msx_pkg::config_t conf;
   logic [15:0]      addr;
   logic [7:0]       d_from_cpu;
   logic             wr_n;
   logic             rd_n;
   logic             iorq_n;
   logic             mreq_n;
   logic [7:0]       d_to_cpu;
   logic             dataBusRQ;
   logic [7:0]       ram_bank;
   logic [3:0]       SLTSL_n;

   // reference state, index 0 is MSX1
   logic [7:0]  slot_m [0:1];
   logic [7:0]  mapper_m [0:3];
   logic [16:0] vaddr_m [0:1];
   logic [7:0]  ctrl_lo_m [0:1];
   logic        ctrl_second_m [0:1];
   logic [7:0]  vram_m [0:131071];

   result_t exp_q [$];
   result_t act_q [$];
   int      n_errors = 0;
   int      n_checks = 0;

   msx_top UUT (
      .clk21m(clk21m), .ce_10m7_p(ce_10m7_p), .reset(reset), .conf(conf), .addr(addr),
      .d_from_cpu(d_from_cpu), .wr_n(wr_n), .rd_n(rd_n), .iorq_n(iorq_n),
      .mreq_n(mreq_n), .d_to_cpu(d_to_cpu), .dataBusRQ(dataBusRQ),
      .ram_bank(ram_bank), .SLTSL_n(SLTSL_n)
   );

   always #5 clk21m = ~clk21m;

   // half-rate enable
   always @(negedge clk21m) ce_10m7_p <= ~ce_10m7_p;

   function automatic logic [7:0] rand8();
      return 8'($urandom);
   endfunction

   // 2 bits at 64 KB up to 5 bits at 512 KB
   function automatic logic [7:0] mapper_mask(input logic [1:0] ram_size);
      return 8'((9'd4 << ram_size) - 9'd1);
   endfunction

   function automatic result_t predict(input logic is_mem, input logic [7:0] port,
                                       input logic [1:0] page);
      result_t    r;
      logic       m;
      logic [7:0] mask;
      m    = conf.typ == msx_pkg::MSX2;
      mask = mapper_mask(conf.ram_size);
      r    = '0;
      r.is_mem = is_mem;
      if (is_mem) begin
         r.bank    = m ? mapper_m[page] : {6'd0, page};
         r.sltsl_n = ~(4'd1 << slot_m[m][{page, 1'b0} +: 2]);
      end else if (port == msx_pkg::PORT_SLOT) begin
         r.rq = 1'b1;
         r.d  = slot_m[m];
      end else if (port == msx_pkg::PORT_VDP_DATA) begin
         r.rq = 1'b1;
         r.d  = vram_m[vaddr_m[m]];
      end else if (port >= msx_pkg::PORT_MAPPER && m) begin
         r.rq = 1'b1;
         r.d  = mapper_m[port[1:0]] | ~mask;
      end
      return r;
   endfunction

   // MSX1 wraps at 16 KB, MSX2 at 128 KB
   task automatic step_vaddr(input logic m);
      if (m) vaddr_m[m] = vaddr_m[m] + 17'd1;
      else vaddr_m[m] = {3'd0, vaddr_m[m][13:0] + 14'd1};
   endtask

   task automatic model_write(input logic [7:0] port, input logic [7:0] data);
      logic m;
      m = conf.typ == msx_pkg::MSX2;
      if (port == msx_pkg::PORT_SLOT) begin
         slot_m[m] = data;
      end else if (port >= msx_pkg::PORT_MAPPER) begin
         if (m) mapper_m[port[1:0]] = data & mapper_mask(conf.ram_size);
      end else if (port == msx_pkg::PORT_VDP_CTRL) begin
         if (!ctrl_second_m[m]) begin
            ctrl_lo_m[m] = data;
         end else if (!data[7]) begin
            vaddr_m[m][13:0] = {data[5:0], ctrl_lo_m[m]};
         end else if (m && data[5:0] == 6'd14) begin
            vaddr_m[m][16:14] = ctrl_lo_m[m][2:0];
         end
         ctrl_second_m[m] = !ctrl_second_m[m];
      end else if (port == msx_pkg::PORT_VDP_DATA) begin
         vram_m[vaddr_m[m]] = data;
         step_vaddr(m);
      end
   endtask

   task automatic compare(input string name, input logic [7:0] want, input logic [7:0] got);
      n_checks++;
      if (got !== want) begin
         n_errors++;
         $display("FAILED at %0t ns: %s expected %02h, got %02h", $time, name, want, got);
      end
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      addr       = {8'h00, port};
      d_from_cpu = data;
      iorq_n     = 1'b0;
      wr_n       = 1'b0;
      repeat (STROBE_CYC) @(negedge clk21m);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      model_write(port, data);
      repeat (IDLE_CYC) @(negedge clk21m);
   endtask

   task automatic io_read(input logic [7:0] port);
      result_t act;
      addr   = {8'h00, port};
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      repeat (STROBE_CYC - 2) @(negedge clk21m);
      act    = '0;
      act.rq = dataBusRQ;
      act.d  = d_to_cpu;
      exp_q.push_back(predict(1'b0, port, 2'd0));
      act_q.push_back(act);
      repeat (2) @(negedge clk21m);
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      if (port == msx_pkg::PORT_VDP_DATA) step_vaddr(conf.typ == msx_pkg::MSX2);
      repeat (IDLE_CYC) @(negedge clk21m);
   endtask

   task automatic mem_cycle(input logic [1:0] page);
      result_t act;
      addr   = {page, 14'($urandom)};
      mreq_n = 1'b0;
      rd_n   = 1'b0;
      repeat (STROBE_CYC - 2) @(negedge clk21m);
      act         = '0;
      act.is_mem  = 1'b1;
      act.bank    = ram_bank;
      act.sltsl_n = SLTSL_n;
      exp_q.push_back(predict(1'b1, 8'h00, page));
      act_q.push_back(act);
      repeat (2) @(negedge clk21m);
      mreq_n = 1'b1;
      rd_n   = 1'b1;
      repeat (IDLE_CYC) @(negedge clk21m);
   endtask

   task automatic set_machine(input msx_pkg::machine_t typ, input logic [1:0] ram_size);
      conf.typ      = typ;
      conf.ram_size = ram_size;
      @(negedge clk21m);
   endtask

   task automatic set_vram_addr(input logic [13:0] a, input logic for_write);
      io_write(msx_pkg::PORT_VDP_CTRL, a[7:0]);
      io_write(msx_pkg::PORT_VDP_CTRL, {1'b0, for_write, a[13:8]});
   endtask

   task automatic write_vdp_reg(input logic [5:0] num, input logic [7:0] value);
      io_write(msx_pkg::PORT_VDP_CTRL, value);
      io_write(msx_pkg::PORT_VDP_CTRL, {2'b10, num});
   endtask

   task automatic fill_vram(input int n);
      repeat (n) io_write(msx_pkg::PORT_VDP_DATA, rand8());
   endtask

   task automatic read_vram(input int n);
      repeat (n) io_read(msx_pkg::PORT_VDP_DATA);
   endtask

   always @(posedge clk21m) begin
      result_t e;
      result_t a;
      while (act_q.size() > 0) begin
         e = exp_q.pop_front();
         a = act_q.pop_front();
         if (e.is_mem) begin
            compare("ram_bank", e.bank, a.bank);
            compare("SLTSL_n", {4'h0, e.sltsl_n}, {4'h0, a.sltsl_n});
         end else begin
            compare("dataBusRQ", {7'd0, e.rq}, {7'd0, a.rq});
            if (e.rq) compare("d_to_cpu", e.d, a.d);
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: bus tests did not finish within %0d ns", TIMEOUT_NS);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      logic [13:0] base;
      void'($urandom(32'h0fb9_728f));
      for (int i = 0; i < 2; i++) begin
         slot_m[i]        = 8'h00;
         vaddr_m[i]       = 17'd0;
         ctrl_lo_m[i]     = 8'h00;
         ctrl_second_m[i] = 1'b0;
      end
      for (int i = 0; i < 4; i++) mapper_m[i] = 8'(3 - i);
      ce_10m7_p  = 1'b0;
      reset      = 1'b1;
      conf       = '{typ: msx_pkg::MSX1, ram_size: 2'd3};
      addr       = 16'h0000;
      d_from_cpu = 8'h00;
      wr_n       = 1'b1;
      rd_n       = 1'b1;
      iorq_n     = 1'b1;
      mreq_n     = 1'b1;
      repeat (4) @(negedge clk21m);
      reset = 1'b0;
      @(negedge clk21m);

      // slot register and slot selects on both machines
      for (int t = 0; t < 2; t++) begin
         set_machine(t == 0 ? msx_pkg::MSX1 : msx_pkg::MSX2, 2'd3);
         for (int p = 0; p < 4; p++) mem_cycle(2'(p));
         repeat (4) begin
            io_write(msx_pkg::PORT_SLOT, rand8());
            io_read(msx_pkg::PORT_SLOT);
            for (int p = 0; p < 4; p++) mem_cycle(2'(p));
         end
      end

      // mapper over all ram sizes
      for (int rs = 0; rs < 4; rs++) begin
         set_machine(msx_pkg::MSX2, 2'(rs));
         for (int p = 0; p < 4; p++) io_write(msx_pkg::PORT_MAPPER | 8'(p), rand8());
         for (int p = 0; p < 4; p++) io_read(msx_pkg::PORT_MAPPER | 8'(p));
         for (int p = 0; p < 4; p++) mem_cycle(2'(p));
      end
      set_machine(msx_pkg::MSX1, 2'd3);
      for (int p = 0; p < 4; p++) mem_cycle(2'(p));
      io_read(msx_pkg::PORT_MAPPER);

      // MSX1 block, then across the 16 KB wrap
      base = 14'($urandom);
      set_vram_addr(base, 1'b1);
      fill_vram(16);
      set_vram_addr(base, 1'b0);
      read_vram(16);
      set_vram_addr(14'h3FFC, 1'b1);
      fill_vram(8);
      set_vram_addr(14'h3FFC, 1'b0);
      read_vram(8);

      // MSX2 low bank, then the same offsets in the high bank
      set_machine(msx_pkg::MSX2, 2'd3);
      base = 14'($urandom);
      write_vdp_reg(6'd14, 8'h00);
      set_vram_addr(base, 1'b1);
      fill_vram(16);
      write_vdp_reg(6'd14, 8'h04);
      set_vram_addr(base, 1'b1);
      fill_vram(16);
      write_vdp_reg(6'd14, 8'h00);
      set_vram_addr(base, 1'b0);
      read_vram(16);
      write_vdp_reg(6'd14, 8'h04);
      set_vram_addr(base, 1'b0);
      read_vram(16);

      // register writes between data writes, both machines
      for (int t = 0; t < 2; t++) begin
         set_machine(t == 0 ? msx_pkg::MSX2 : msx_pkg::MSX1, 2'd3);
         base = 14'($urandom);
         set_vram_addr(base, 1'b1);
         repeat (8) begin
            io_write(msx_pkg::PORT_VDP_DATA, rand8());
            write_vdp_reg({3'd0, 3'($urandom)}, rand8());
         end
         set_vram_addr(base, 1'b0);
         read_vram(8);
      end

      // machine switch keeps the idle core frozen
      io_write(msx_pkg::PORT_SLOT, rand8());
      set_machine(msx_pkg::MSX2, 2'd3);
      io_write(msx_pkg::PORT_SLOT, rand8());
      io_read(msx_pkg::PORT_SLOT);
      set_machine(msx_pkg::MSX1, 2'd3);
      io_read(msx_pkg::PORT_SLOT);
      for (int p = 0; p < 4; p++) mem_cycle(2'(p));

      repeat (4) @(negedge clk21m);
      $display("checks: %0d, value errors: %0d, assertion errors: %0d",
               n_checks, n_errors, UUT.chk.fail_count);
      if (n_errors == 0 && UUT.chk.fail_count == 0 && act_q.size() == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* sim.f */
verilog/msx_pkg.sv
verilog/spram.sv
verilog/msx_bus_decode.sv
verilog/msx1_core.sv
verilog/msx2_core.sv
verilog/msx_select.sv
verilog/msx_top.sv
verif/msx_chk.sv
verif/tb_msx.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_msx
FILELIST   = sim.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
